//--- all.f
hdl/hififo_pkg.sv
hdl/sync_fifo.sv
hdl/reset_stretch.sv
hdl/fpc_channel.sv
hdl/hififo_regs.sv
hdl/hififo_ctrl.sv
tests/hififo_ctrl_tb.sv

//--- hdl/fpc_channel.sv
`timescale 1ns/1ps

module fpc_channel
   #(
      parameter int CHANNEL    = 0,
      parameter int DEPTH_LOG2 = 4,
      parameter int NB         = 4
   )
   (
      input  logic                     clock,
      input  logic                     reset_req,
      input  hififo_pkg::pio_write_t   pio_write,
      output hififo_pkg::chan_status_t status,
      output logic                     drain_irq,
      input  logic                     fifo_read,
      output logic [63:0]              fifo_data,
      output logic                     fifo_valid,
      output logic                     fifo_reset
   );

   localparam logic [5:0] ADDRESS = 6'(hififo_pkg::CHANNEL_BASE + CHANNEL);

   logic        push_hit;
   logic        pushed;
   logic        popped;
   logic        fifo_pop;
   logic        full;
   logic        overflow;
   logic [15:0] count;

   assign push_hit = pio_write.valid && (pio_write.address == ADDRESS);
   assign pushed = push_hit && !full;
   // user reads are ignored while the channel is held in reset
   assign fifo_pop = fifo_read && !fifo_reset;
   assign popped = fifo_pop && fifo_valid;

   reset_stretch #(.NB(NB)) i_reset_stretch
      (
         .clock   (clock),
         .request (reset_req),
         .reset   (fifo_reset)
      );

   sync_fifo #(.DEPTH_LOG2(DEPTH_LOG2)) i_sync_fifo
      (
         .clock      (clock),
         .reset      (fifo_reset),
         .push       (push_hit),
         .push_data  (pio_write.data),
         .pop        (fifo_pop),
         .head_data  (fifo_data),
         .head_valid (fifo_valid),
         .full       (full),
         .count      (count)
      );

   always_ff @(posedge clock)
   begin
      if (fifo_reset)
      begin
         overflow <= 1'b0;
         drain_irq <= 1'b0;
      end
      else
      begin
         // sticky until the channel is reset
         if (push_hit && full)
            overflow <= 1'b1;
         // last word leaves with nothing coming in behind it
         drain_irq <= popped && !pushed && (count == 16'd1);
      end
   end

   assign status.reserved = '0;
   assign status.overflow = overflow;
   assign status.occupancy = count;

endmodule

//--- hdl/hififo_ctrl.sv
`timescale 1ns/1ps

module hififo_ctrl
   #(
      parameter logic [7:0] ENABLE     = 8'h0F,
      parameter int         DEPTH_LOG2 = 4,
      parameter int         NB         = 4
   )
   (
      input  logic                    clock,
      input  logic                    pci_reset,
      input  hififo_pkg::pio_write_t  pio_write,
      input  hififo_pkg::read_req_t   read_req,
      input  logic                    rr_valid,
      output logic                    rr_ready,
      output hififo_pkg::completion_t completion,
      output logic                    rc_valid,
      input  logic                    rc_ready,
      output logic                    interrupt,
      input  logic                    interrupt_rdy,
      input  logic [3:0]              fifo_read,
      output logic [63:0]             fifo_data [4],
      output logic [3:0]              fifo_valid,
      output logic [3:0]              fifo_reset
   );

   hififo_pkg::chan_status_t            chan_status [hififo_pkg::NUM_CHANNELS];
   logic [hififo_pkg::NUM_CHANNELS-1:0] drain_irq;
   // upper four bits belong to the to-PC side and only read back
   logic [7:0]                          fifo_reset_req;

   hififo_regs #(.ENABLE(ENABLE)) i_hififo_regs
      (
         .clock          (clock),
         .pci_reset      (pci_reset),
         .pio_write      (pio_write),
         .read_req       (read_req),
         .rr_valid       (rr_valid),
         .rr_ready       (rr_ready),
         .completion     (completion),
         .rc_valid       (rc_valid),
         .rc_ready       (rc_ready),
         .chan_status    (chan_status),
         .drain_irq      (drain_irq),
         .fifo_reset_req (fifo_reset_req),
         .interrupt      (interrupt),
         .interrupt_rdy  (interrupt_rdy)
      );

   for (genvar i = 0; i < hififo_pkg::NUM_CHANNELS; i++)
   begin : g_chan
      if (ENABLE[i])
      begin : g_on
         fpc_channel
            #(
               .CHANNEL    (i),
               .DEPTH_LOG2 (DEPTH_LOG2),
               .NB         (NB)
            )
            i_fpc_channel
            (
               .clock      (clock),
               .reset_req  (fifo_reset_req[i]),
               .pio_write  (pio_write),
               .status     (chan_status[i]),
               .drain_irq  (drain_irq[i]),
               .fifo_read  (fifo_read[i]),
               .fifo_data  (fifo_data[i]),
               .fifo_valid (fifo_valid[i]),
               .fifo_reset (fifo_reset[i])
            );
      end
      else
      begin : g_off
         // empty slot looks like a channel stuck in reset
         assign chan_status[i] = '0;
         assign drain_irq[i] = 1'b0;
         assign fifo_data[i] = '0;
         assign fifo_valid[i] = 1'b0;
         assign fifo_reset[i] = 1'b1;
      end
   end

endmodule

//--- hdl/hififo_pkg.sv
package hififo_pkg;

   // from-PC channel slots and where they sit in PIO space
   parameter int NUM_CHANNELS = 4;
   parameter int CHANNEL_BASE = 8;

   // one decoded PIO write, strobed by valid
   typedef struct packed
   {
      logic        valid;
      logic [5:0]  address;
      logic [63:0] data;
   } pio_write_t;

   // register read request from the receive path
   typedef struct packed
   {
      logic [23:0] rid_tag;
      logic [7:0]  address;
   } read_req_t;

   // read completion handed to the transmit path
   typedef struct packed
   {
      logic [31:0] dw2;
      logic [31:0] data;
   } completion_t;

   // register numbers, read address bits 4 to 1
   typedef enum logic [3:0]
   {
      REG_INT_STATUS  = 4'd0,
      REG_ENABLE      = 4'd1,
      REG_RESET_SET   = 4'd3,
      REG_RESET_CLEAR = 4'd4,
      REG_STATUS_0    = 4'd8,
      REG_STATUS_1    = 4'd9,
      REG_STATUS_2    = 4'd10,
      REG_STATUS_3    = 4'd11
   } reg_index_e;

   typedef enum logic [1:0]
   {
      READ_IDLE,
      READ_DECODE,
      READ_FETCH,
      READ_RESPOND
   } read_state_e;

   // occupancy in the low half, overflow at bit 16
   typedef struct packed
   {
      logic [14:0] reserved;
      logic        overflow;
      logic [15:0] occupancy;
   } chan_status_t;

endpackage

//--- hdl/hififo_regs.sv
`timescale 1ns/1ps

module hififo_regs
   #(
      parameter logic [7:0] ENABLE = 8'h0F
   )
   (
      input  logic                              clock,
      input  logic                              pci_reset,
      input  hififo_pkg::pio_write_t            pio_write,
      input  hififo_pkg::read_req_t             read_req,
      input  logic                              rr_valid,
      output logic                              rr_ready,
      output hififo_pkg::completion_t           completion,
      output logic                              rc_valid,
      input  logic                              rc_ready,
      input  hififo_pkg::chan_status_t          chan_status [hififo_pkg::NUM_CHANNELS],
      input  logic [hififo_pkg::NUM_CHANNELS-1:0] drain_irq,
      output logic [7:0]                        fifo_reset_req,
      output logic                              interrupt,
      input  logic                              interrupt_rdy
   );

   hififo_pkg::read_state_e             read_state;
   hififo_pkg::reg_index_e              read_index;
   logic [hififo_pkg::NUM_CHANNELS-1:0] int_status;
   logic [31:0]                         read_data;
   logic                                int_clear;
   logic                                reset_set_hit;
   logic                                reset_clear_hit;

   assign reset_set_hit = pio_write.valid &&
                          (pio_write.address == 6'(hififo_pkg::REG_RESET_SET));
   assign reset_clear_hit = pio_write.valid &&
                            (pio_write.address == 6'(hififo_pkg::REG_RESET_CLEAR));

   // set/clear FIFO reset register, all channels held after pci_reset
   always_ff @(posedge clock)
   begin
      if (pci_reset)
         fifo_reset_req <= 8'hFF;
      else if (reset_set_hit)
         fifo_reset_req <= fifo_reset_req | pio_write.data[7:0];
      else if (reset_clear_hit)
         fifo_reset_req <= fifo_reset_req & ~pio_write.data[7:0];
   end

   // reading the status clears it, anything arriving that cycle is dropped
   assign int_clear = (read_state == hififo_pkg::READ_FETCH) &&
                      (read_index == hififo_pkg::REG_INT_STATUS);

   always_ff @(posedge clock)
   begin
      if (pci_reset)
         int_status <= '0;
      else if (int_clear)
         int_status <= '0;
      else
         int_status <= int_status | drain_irq;
   end

   // level interrupt, held until the core takes it
   always_ff @(posedge clock)
   begin
      if (pci_reset)
         interrupt <= 1'b0;
      else
         interrupt <= (drain_irq != '0) || (interrupt && !interrupt_rdy);
   end

   always_comb
   begin
      case (read_index)
         hififo_pkg::REG_INT_STATUS:  read_data = 32'(int_status);
         hififo_pkg::REG_ENABLE:      read_data = 32'(ENABLE);
         hififo_pkg::REG_RESET_SET:   read_data = 32'(fifo_reset_req);
         hififo_pkg::REG_RESET_CLEAR: read_data = 32'(fifo_reset_req);
         hififo_pkg::REG_STATUS_0:    read_data = chan_status[0];
         hififo_pkg::REG_STATUS_1:    read_data = chan_status[1];
         hififo_pkg::REG_STATUS_2:    read_data = chan_status[2];
         hififo_pkg::REG_STATUS_3:    read_data = chan_status[3];
         default:                     read_data = '0;
      endcase
   end

   // one read at a time: idle, decode, fetch, then hold until accepted
   always_ff @(posedge clock)
   begin
      if (pci_reset)
      begin
         read_state <= hififo_pkg::READ_IDLE;
         rc_valid <= 1'b0;
         rr_ready <= 1'b0;
      end
      else
      begin
         rr_ready <= 1'b0;
         case (read_state)
            hififo_pkg::READ_IDLE:
            begin
               // the request just acknowledged is still on the bus this cycle
               if (rr_valid && !rr_ready)
                  read_state <= hififo_pkg::READ_DECODE;
            end
            hififo_pkg::READ_DECODE:
               read_state <= hififo_pkg::READ_FETCH;
            hififo_pkg::READ_FETCH:
            begin
               rc_valid <= 1'b1;
               read_state <= hififo_pkg::READ_RESPOND;
            end
            hififo_pkg::READ_RESPOND:
            begin
               if (rc_ready)
               begin
                  rc_valid <= 1'b0;
                  rr_ready <= 1'b1;
                  read_state <= hififo_pkg::READ_IDLE;
               end
            end
            default:
               read_state <= hififo_pkg::READ_IDLE;
         endcase
      end
   end

   // completion payload, only loaded before rc_valid rises
   always_ff @(posedge clock)
   begin
      if (read_state == hififo_pkg::READ_DECODE)
      begin
         read_index <= hififo_pkg::reg_index_e'(read_req.address[4:1]);
         completion.dw2 <= {read_req.rid_tag, 1'b0, read_req.address[4:0], 2'b00};
      end
      if (read_state == hififo_pkg::READ_FETCH)
         completion.data <= read_data;
   end

endmodule

//--- hdl/reset_stretch.sv
`timescale 1ns/1ps

module reset_stretch
   #(
      parameter int NB = 4
   )
   (
      input  logic clock,
      input  logic request,
      output logic reset
   );

   localparam int CW = $clog2(NB + 1);

   logic [CW-1:0] remaining;

   // reload while requested, then count down before letting go
   always_ff @(posedge clock)
   begin
      if (request)
      begin
         remaining <= CW'(NB);
         reset <= 1'b1;
      end
      else if (remaining != '0)
      begin
         remaining <= remaining - 1'b1;
         reset <= 1'b1;
      end
      else
         reset <= 1'b0;
   end

endmodule

//--- hdl/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo
   #(
      parameter int DEPTH_LOG2 = 4
   )
   (
      input  logic        clock,
      input  logic        reset,
      input  logic        push,
      input  logic [63:0] push_data,
      input  logic        pop,
      output logic [63:0] head_data,
      output logic        head_valid,
      output logic        full,
      output logic [15:0] count
   );

   localparam int DEPTH = 2 ** DEPTH_LOG2;

   logic [63:0]           mem [DEPTH];
   logic [DEPTH_LOG2-1:0] rd_ptr;
   logic [DEPTH_LOG2-1:0] wr_ptr;
   logic [DEPTH_LOG2:0]   level;
   logic                  do_push;
   logic                  do_pop;

   // pushes into a full FIFO are dropped here
   assign do_push = push && !full;
   assign do_pop = pop && head_valid;

   assign head_valid = (level != '0);
   // level never exceeds DEPTH, so the top bit alone means full
   assign full = level[DEPTH_LOG2];
   assign head_data = mem[rd_ptr];
   assign count = 16'(level);

   always_ff @(posedge clock)
   begin
      if (do_push)
         mem[wr_ptr] <= push_data;
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         level <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10: level <= level + 1'b1;
            2'b01: level <= level - 1'b1;
            default: level <= level;
         endcase
      end
   end

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f all.f --top-module hififo_ctrl_tb
./obj_dir/Vhififo_ctrl_tb > sim.log
cat sim.log
if grep -q "Some tests failed" sim.log
then
   exit 1
fi

//--- tests/hififo_ctrl_tb.sv
`timescale 1ns/1ps

module hififo_ctrl_tb;

   localparam logic [7:0] ENABLE = 8'h0B;
   localparam int DEPTH = 4;
   localparam int RESET_CYCLES = 10;

   typedef enum logic [2:0]
   {
      OP_WRITE,
      OP_READ,
      OP_POP,
      OP_IDLE,
      OP_ACK_IRQ
   } op_e;

   // read rows carry the requester id and tag in data
   typedef struct packed
   {
      op_e         op;
      int          test;
      logic [7:0]  addr;
      logic [63:0] data;
      int          delay;
      logic [63:0] expected;
   } row_t;

   logic                    clock;
   logic                    pci_reset;
   hififo_pkg::pio_write_t  pio_write;
   hififo_pkg::read_req_t   read_req;
   logic                    rr_valid;
   logic                    rr_ready;
   hififo_pkg::completion_t completion;
   logic                    rc_valid;
   logic                    rc_ready;
   logic                    interrupt;
   logic                    interrupt_rdy;
   logic [3:0]              fifo_read;
   logic [63:0]             fifo_data [4];
   logic [3:0]              fifo_valid;
   logic [3:0]              fifo_reset;

   row_t        rows [$];
   logic        table_ready;
   logic [63:0] rng_state;
   int          build_test;
   int          checks;
   int          errors;
   int          test_errors;
   int          tests_failed;
   // reference model stepped while the table is built
   logic [63:0] model_q [4][$];
   logic [3:0]  model_overflow;
   logic [3:0]  model_int_status;
   logic [7:0]  model_reset_reg;
   logic        model_irq;

   hififo_ctrl #(.ENABLE(ENABLE), .DEPTH_LOG2(2), .NB(4)) i_hififo_ctrl
      (
         .clock         (clock),
         .pci_reset     (pci_reset),
         .pio_write     (pio_write),
         .read_req      (read_req),
         .rr_valid      (rr_valid),
         .rr_ready      (rr_ready),
         .completion    (completion),
         .rc_valid      (rc_valid),
         .rc_ready      (rc_ready),
         .interrupt     (interrupt),
         .interrupt_rdy (interrupt_rdy),
         .fifo_read     (fifo_read),
         .fifo_data     (fifo_data),
         .fifo_valid    (fifo_valid),
         .fifo_reset    (fifo_reset)
      );

   initial
   begin
      clock = 1'b0;
      forever #20 clock = ~clock;
   end

   function automatic logic [63:0] next_word();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 7);
      rng_state = rng_state ^ (rng_state << 17);
      return rng_state;
   endfunction

   // header holds id and tag, a zero bit, address bits 4 to 0 and two zero bits
   function automatic logic [31:0] make_dw2(input logic [23:0] rid_tag, input logic [7:0] addr);
      return {rid_tag, 1'b0, addr[4:0], 2'b00};
   endfunction

   task automatic add_row(input op_e op, input logic [7:0] addr, input logic [63:0] data,
                          input int delay, input logic [63:0] expected);
      row_t r;
      r.op = op;
      r.test = build_test;
      r.addr = addr;
      r.data = data;
      r.delay = delay;
      r.expected = expected;
      rows.push_back(r);
   endtask

   task automatic add_write(input logic [5:0] addr, input logic [63:0] data);
      int ch;
      ch = int'(addr) - hififo_pkg::CHANNEL_BASE;
      if (addr == 6'd3)
         model_reset_reg = model_reset_reg | data[7:0];
      else if (addr == 6'd4)
         model_reset_reg = model_reset_reg & ~data[7:0];
      else if (ch >= 0 && ch < 4 && ENABLE[ch] && !model_reset_reg[ch])
      begin
         if (model_q[ch].size() < DEPTH)
            model_q[ch].push_back(data);
         else
            model_overflow[ch] = 1'b1;
      end
      // a channel held in reset loses its words and overflow
      for (int i = 0; i < 4; i++)
      begin
         if (model_reset_reg[i])
         begin
            model_q[i].delete();
            model_overflow[i] = 1'b0;
         end
      end
      add_row(OP_WRITE, 8'(addr), data, 0, '0);
   endtask

   task automatic add_read(input logic [7:0] addr, input int delay);
      logic [31:0] value;
      logic [63:0] rid;
      int          ch;
      ch = int'(addr[4:1]) - 8;
      rid = next_word();
      // register index from address bits 4 to 1
      case (addr[4:1])
         4'd0:
         begin
            value = 32'(model_int_status);
            model_int_status = '0;
         end
         4'd1: value = 32'(ENABLE);
         4'd3, 4'd4: value = 32'(model_reset_reg);
         4'd8, 4'd9, 4'd10, 4'd11:
            value = {15'd0, model_overflow[ch], 16'(model_q[ch].size())};
         default: value = '0;
      endcase
      add_row(OP_READ, addr, {40'd0, rid[23:0]}, delay, {32'd0, value});
   endtask

   task automatic add_pop(input int ch);
      logic [63:0] word;
      word = model_q[ch].pop_front();
      // draining pop raises the channel's interrupt bit
      if (model_q[ch].size() == 0)
      begin
         model_int_status[ch] = 1'b1;
         model_irq = 1'b1;
      end
      add_row(OP_POP, 8'(ch), '0, 0, word);
   endtask

   // expected is {interrupt, fifo_reset, fifo_valid}
   task automatic add_idle(input int cycles);
      logic [3:0] resets;
      logic [3:0] valids;
      for (int i = 0; i < 4; i++)
      begin
         resets[i] = ENABLE[i] ? model_reset_reg[i] : 1'b1;
         valids[i] = (model_q[i].size() != 0);
      end
      add_row(OP_IDLE, '0, '0, cycles, {55'd0, model_irq, resets, valids});
   endtask

   task automatic add_ack_irq();
      add_row(OP_ACK_IRQ, '0, '0, 0, {63'd0, model_irq});
      model_irq = 1'b0;
   endtask

   task automatic build_table();
      build_test = 1;
      add_idle(2);
      add_read(8'h02, 0);
      add_read(8'h06, 0);
      add_read(8'h08, 0);
      add_read(8'h00, 0);
      build_test = 2;
      add_write(6'd4, 64'h0F);
      add_idle(8);
      repeat (3) add_write(6'd8, next_word());
      repeat (2) add_write(6'd9, next_word());
      add_write(6'd10, next_word());
      add_idle(2);
      add_pop(0);
      add_pop(1);
      add_read(8'h10, 1);
      add_read(8'h12, 0);
      add_read(8'h14, 0);
      build_test = 3;
      repeat (5) add_write(6'd11, next_word());
      add_idle(2);
      add_read(8'h16, 0);
      add_write(6'd3, 64'h08);
      add_idle(3);
      add_read(8'h16, 0);
      add_write(6'd4, 64'h08);
      add_idle(8);
      add_read(8'h16, 0);
      add_read(8'h06, 0);
      build_test = 4;
      add_pop(0);
      add_pop(0);
      add_idle(3);
      add_idle(4);
      add_ack_irq();
      add_idle(1);
      add_read(8'h00, 0);
      add_read(8'h00, 0);
      build_test = 5;
      add_read(8'h03, 3);
      add_read(8'h13, 5);
      add_read(8'hFE, 2);
      build_test = 6;
      add_read(8'h14, 0);
      add_write(6'd4, 64'h04);
      add_idle(8);
      add_write(6'd10, next_word());
      add_idle(2);
      add_read(8'h14, 0);
   endtask

   task automatic check(input string name, input logic [63:0] actual,
                        input logic [63:0] expected);
      checks++;
      if (actual !== expected)
      begin
         $display("[ERROR] %0d ns %s: got %h, expected %h", $time, name, actual, expected);
         errors++;
         test_errors++;
      end
   endtask

   task automatic apply_read(input row_t r);
      hififo_pkg::completion_t held;
      int                      cycles;
      read_req.rid_tag = r.data[23:0];
      read_req.address = r.addr;
      rr_valid = 1'b1;
      cycles = 0;
      do
      begin
         @(negedge clock);
         cycles++;
      end
      while (!rc_valid && cycles < 20);
      if (!rc_valid)
      begin
         $display("at %0d ns no completion arrived for a read of %h", $time, r.addr);
         errors++;
         test_errors++;
         rr_valid = 1'b0;
         return;
      end
      check("rc_valid latency", 64'(cycles), 64'd3);
      held = completion;
      // completion holds while the sink stalls
      for (int i = 0; i < r.delay; i++)
      begin
         @(negedge clock);
         check("completion", completion, held);
         check("rc_valid", 64'(rc_valid), 64'd1);
         check("rr_ready", 64'(rr_ready), 64'd0);
      end
      check("completion.data", 64'(completion.data), r.expected);
      check("completion.dw2", 64'(completion.dw2), 64'(make_dw2(r.data[23:0], r.addr)));
      rc_ready = 1'b1;
      @(negedge clock);
      rc_ready = 1'b0;
      check("rr_ready", 64'(rr_ready), 64'd1);
      check("rc_valid", 64'(rc_valid), 64'd0);
      rr_valid = 1'b0;
      @(negedge clock);
      check("rr_ready", 64'(rr_ready), 64'd0);
   endtask

   task automatic apply_row(input row_t r);
      case (r.op)
         OP_WRITE:
         begin
            pio_write.valid = 1'b1;
            pio_write.address = r.addr[5:0];
            pio_write.data = r.data;
            @(negedge clock);
            pio_write = '0;
         end
         OP_READ: apply_read(r);
         OP_POP:
         begin
            check($sformatf("fifo_valid[%0d]", r.addr), 64'(fifo_valid[r.addr]), 64'd1);
            check($sformatf("fifo_data[%0d]", r.addr), fifo_data[r.addr], r.expected);
            fifo_read[r.addr] = 1'b1;
            @(negedge clock);
            fifo_read = '0;
         end
         OP_IDLE:
         begin
            repeat (r.delay) @(negedge clock);
            check("interrupt", 64'(interrupt), 64'(r.expected[8]));
            check("fifo_reset", 64'(fifo_reset), 64'(r.expected[7:4]));
            check("fifo_valid", 64'(fifo_valid), 64'(r.expected[3:0]));
         end
         default:
         begin
            check("interrupt", 64'(interrupt), r.expected);
            interrupt_rdy = 1'b1;
            @(negedge clock);
            interrupt_rdy = 1'b0;
         end
      endcase
   endtask

   initial
   begin
      pci_reset = 1'b1;
      pio_write = '0;
      read_req = '0;
      rr_valid = 1'b0;
      rc_ready = 1'b0;
      interrupt_rdy = 1'b0;
      fifo_read = '0;
      table_ready = 1'b0;
      checks = 0;
      errors = 0;
      test_errors = 0;
      tests_failed = 0;
      rng_state = 64'd54320;
      model_overflow = '0;
      model_int_status = '0;
      model_reset_reg = 8'hFF;
      model_irq = 1'b0;
      build_table();
      table_ready = 1'b1;
      repeat (RESET_CYCLES) @(negedge clock);
      pci_reset = 1'b0;
      foreach (rows[n])
      begin
         apply_row(rows[n]);
         if (n == rows.size() - 1 || rows[n + 1].test != rows[n].test)
         begin
            $display("test %0d: %0d errors", rows[n].test, test_errors);
            if (test_errors != 0)
               tests_failed++;
            test_errors = 0;
         end
      end
      $display("%0d checks, %0d errors, %0d tests failed", checks, errors, tests_failed);
      if (errors == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

   // fifty cycles per table row after reset
   initial
   begin
      wait (table_ready);
      repeat (RESET_CYCLES + 50 * rows.size()) @(posedge clock);
      $display("watchdog expired at %0d ns before the table finished", $time);
      $display("Some tests failed");
      $finish;
   end

endmodule
